// ==== common/mul_pkg.sv ====
// Multiplier arithmetic constants
package mul_pkg;

  // Operand and product widths
  localparam int op_width   = 16;
  localparam int byte_width = 8;
  localparam int prod_width = 32;

  // Carry-lookahead grouping for the 32-bit adders
  localparam int group_width = 4;
  localparam int num_groups  = prod_width / group_width;

  // Cross products land one byte up
  localparam int cross_shift = 8;

  // Start to done latency of the core
  localparam int pipe_depth = 2;

endpackage

// ==== common/wb_pkg.sv ====
// Wishbone register map
package wb_pkg;

  localparam int wb_data_width = 32;
  localparam int wb_addr_width = 2;

  // Word addresses
  localparam logic [wb_addr_width-1:0] addr_operands = wb_addr_width'(0);
  localparam logic [wb_addr_width-1:0] addr_product  = wb_addr_width'(1);
  localparam logic [wb_addr_width-1:0] addr_status   = wb_addr_width'(2);

  // Status word layout
  localparam int status_busy_bit = 0;

  // Operand register as seen by the bus and by the core
  // pair[1] is operand b, pair[0] is operand a
  typedef union packed {
    logic [wb_data_width-1:0]                raw;
    logic [1:0][wb_data_width/2-1:0]         pair;
  } operand_word_u;

endpackage

// ==== mul16/array_mul8.sv ====
// Exact 8x8 carry-save array multiplier
`timescale 1ns/1ps

module array_mul8
  import mul_pkg::*;
(
  input  logic [byte_width-1:0]   a,
  input  logic [byte_width-1:0]   b,
  output logic [2*byte_width-1:0] p
);

  // pp[i][j] = a[j] & b[i], weight 2^(i+j)
  logic [byte_width-1:0] pp [byte_width];
  // Row sums and carries of the carry-save array
  logic [byte_width-1:0] s  [byte_width];
  logic [byte_width-2:0] c  [1:byte_width-1];
  // Carries of the final ripple row
  logic [byte_width-1:1] r;

  genvar i, j;

  generate
    for (i = 0; i < byte_width; i++) begin : g_row
      for (j = 0; j < byte_width; j++) begin : g_and
        assign pp[i][j] = a[j] & b[i];
      end

      // Top bit of each row passes down to the next one
      assign s[i][byte_width-1] = pp[i][byte_width-1];

      if (i == 0) begin : g_first
        assign s[0][byte_width-2:0] = pp[0][byte_width-2:0];
      end else if (i == 1) begin : g_half
        for (j = 0; j < byte_width-1; j++) begin : g_ha
          assign s[1][j] = s[0][j+1] ^ pp[1][j];
          assign c[1][j] = s[0][j+1] & pp[1][j];
        end
      end else begin : g_full
        for (j = 0; j < byte_width-1; j++) begin : g_fa
          assign s[i][j] = s[i-1][j+1] ^ pp[i][j] ^ c[i-1][j];
          assign c[i][j] = (s[i-1][j+1] & pp[i][j]) |
                           (s[i-1][j+1] & c[i-1][j]) |
                           (pp[i][j] & c[i-1][j]);
        end
      end

      // Low product bits fall out of the array one per row
      assign p[i] = s[i][0];
    end

    // Carry-propagate row for the upper byte
    for (j = 0; j < byte_width-1; j++) begin : g_ripple
      if (j == 0) begin : g_ha
        assign p[byte_width] = s[byte_width-1][1] ^ c[byte_width-1][0];
        assign r[1]          = s[byte_width-1][1] & c[byte_width-1][0];
      end else begin : g_fa
        assign p[byte_width+j] = s[byte_width-1][j+1] ^ c[byte_width-1][j] ^ r[j];
        assign r[j+1] = (s[byte_width-1][j+1] & c[byte_width-1][j]) |
                        (s[byte_width-1][j+1] & r[j]) |
                        (c[byte_width-1][j] & r[j]);
      end
    end
  endgenerate

  assign p[2*byte_width-1] = r[byte_width-1];

endmodule

// ==== mul16/cla32.sv ====
// 32-bit two-level carry-lookahead adder
`timescale 1ns/1ps

module cla32
  import mul_pkg::*;
(
  input  logic [prod_width-1:0] a,
  input  logic [prod_width-1:0] b,
  output logic [prod_width-1:0] sum
);

  logic [prod_width-1:0] p, g;
  logic [num_groups-1:0] gp, gg, gc;

  function automatic logic group_gen(input logic [group_width-1:0] pg,
                                     input logic [group_width-1:0] gn);
    logic acc;
    acc = 1'b0;
    for (int n = 0; n < group_width; n++) begin
      acc = gn[n] | (pg[n] & acc);
    end
    return acc;
  endfunction

  assign p = a ^ b;
  assign g = a & b;

  // Group carry-ins straight from group p/g, no carry-in term
  always_comb begin
    logic term;
    for (int k = 0; k < num_groups; k++) begin
      gc[k] = 1'b0;
      for (int m = 0; m < k; m++) begin
        term = gg[m];
        for (int n = m + 1; n < k; n++) begin
          term = term & gp[n];
        end
        gc[k] = gc[k] | term;
      end
    end
  end

  genvar k;

  generate
    for (k = 0; k < num_groups; k++) begin : g_grp
      logic [group_width-1:0] pk, gk, ck;

      assign pk    = p[k*group_width +: group_width];
      assign gk    = g[k*group_width +: group_width];
      assign gp[k] = &pk;
      assign gg[k] = group_gen(pk, gk);

      // Bit carries inside the group
      always_comb begin
        logic term;
        for (int m = 0; m < group_width; m++) begin
          term = gc[k];
          for (int n = 0; n < m; n++) begin
            term = term & pk[n];
          end
          ck[m] = term;
          for (int n = 0; n < m; n++) begin
            term = gk[n];
            for (int q = n + 1; q < m; q++) begin
              term = term & pk[q];
            end
            ck[m] = ck[m] | term;
          end
        end
      end

      assign sum[k*group_width +: group_width] = pk ^ ck;
    end
  endgenerate

endmodule

// ==== mul16/mul16_core.sv ====
// Pipelined 16x16 multiplier
`timescale 1ns/1ps

module mul16_core
  import mul_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  start,
  input  logic [op_width-1:0]   op_a,
  input  logic [op_width-1:0]   op_b,
  output logic                  done,
  output logic                  busy,
  output logic [prod_width-1:0] product
);

  logic [2*byte_width-1:0] pp_ll, pp_hl, pp_lh, pp_hh;
  logic [2*byte_width-1:0] ll_q, hl_q, lh_q, hh_q;
  logic                    v1_q, v2_q;
  logic [prod_width-1:0]   llhh, lh_al, hl_al;
  logic [prod_width-1:0]   sum_mid, sum_fin;
  logic [prod_width-1:0]   prod_q;

  // Byte products, named by a half then b half
  array_mul8 i_mul_ll (.a(op_a[byte_width-1:0]),        .b(op_b[byte_width-1:0]),        .p(pp_ll));
  array_mul8 i_mul_hl (.a(op_a[op_width-1:byte_width]), .b(op_b[byte_width-1:0]),        .p(pp_hl));
  array_mul8 i_mul_lh (.a(op_a[byte_width-1:0]),        .b(op_b[op_width-1:byte_width]), .p(pp_lh));
  array_mul8 i_mul_hh (.a(op_a[op_width-1:byte_width]), .b(op_b[op_width-1:byte_width]), .p(pp_hh));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      v1_q <= 1'b0;
      v2_q <= 1'b0;
    end else begin
      v1_q <= start;
      v2_q <= v1_q;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      ll_q <= pp_ll;
      hl_q <= pp_hl;
      lh_q <= pp_lh;
      hh_q <= pp_hh;
    end
    if (v1_q) begin
      prod_q <= sum_fin;
    end
  end

  // hh and ll do not overlap, so they just concatenate
  assign llhh  = {hh_q, ll_q};
  assign lh_al = {{(prod_width-2*byte_width){1'b0}}, lh_q} << cross_shift;
  assign hl_al = {{(prod_width-2*byte_width){1'b0}}, hl_q} << cross_shift;

  cla32 i_add_lh (.a(llhh),    .b(lh_al), .sum(sum_mid));
  cla32 i_add_hl (.a(sum_mid), .b(hl_al), .sum(sum_fin));

  assign product = prod_q;
  assign done    = v2_q;
  assign busy    = v1_q | v2_q;

  a_done_latency: assert property (@(posedge clk) disable iff (!arst_n)
    start |-> ##pipe_depth done);

endmodule

// ==== hw/wb_mul_regs.sv ====
// Multiplier bus registers
`timescale 1ns/1ps

module wb_mul_regs
  import mul_pkg::*;
  import wb_pkg::*;
(
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [wb_addr_width-1:0] wb_adr,
  input  logic [wb_data_width-1:0] wb_dat_w,
  output logic [wb_data_width-1:0] wb_dat_r,
  output logic                     wb_ack,
  output logic                     start,
  output logic [op_width-1:0]      op_a,
  output logic [op_width-1:0]      op_b,
  input  logic                     done,
  input  logic                     busy,
  input  logic [prod_width-1:0]    product
);

  operand_word_u            opw_q;
  logic [prod_width-1:0]    product_q;
  logic                     req;
  logic                     stall;
  logic                     ack_d;
  logic                     wr_operands;
  logic [wb_data_width-1:0] status_word;
  logic [wb_data_width-1:0] rd_data;

  // The ack cycle itself is not a new request
  assign req = wb_cyc & wb_stb & ~wb_ack;

  // A start still on its way into the core counts as busy
  assign stall = busy | start;

  // Product reads hold off until the pipeline is empty
  assign ack_d       = req & (wb_we | (wb_adr != addr_product) | ~stall);
  assign wr_operands = req & wb_we & (wb_adr == addr_operands);

  always_comb begin
    status_word = '0;
    status_word[status_busy_bit] = stall;
  end

  always_comb begin
    case (wb_adr)
      addr_operands: rd_data = opw_q.raw;
      addr_product:  rd_data = product_q;
      addr_status:   rd_data = status_word;
      default:       rd_data = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack    <= 1'b0;
      start     <= 1'b0;
      wb_dat_r  <= '0;
      opw_q     <= '0;
      product_q <= '0;
    end else begin
      wb_ack <= ack_d;
      start  <= wr_operands;
      if (wr_operands) begin
        opw_q.raw <= wb_dat_w;
      end
      if (ack_d && !wb_we) begin
        wb_dat_r <= rd_data;
      end
      if (done) begin
        product_q <= product;
      end
    end
  end

  assign op_a = opw_q.pair[0];
  assign op_b = opw_q.pair[1];

  a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(wb_ack) |-> $past(wb_cyc && wb_stb));

  a_ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    wb_ack |=> !wb_ack);

endmodule

// ==== hw/wb_mul16_top.sv ====
// Wishbone multiplier top level
`timescale 1ns/1ps

module wb_mul16_top
  import mul_pkg::*;
  import wb_pkg::*;
(
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [wb_addr_width-1:0] wb_adr,
  input  logic [wb_data_width-1:0] wb_dat_w,
  output logic [wb_data_width-1:0] wb_dat_r,
  output logic                     wb_ack
);

  logic                  start;
  logic                  done;
  logic                  busy;
  logic [op_width-1:0]   op_a;
  logic [op_width-1:0]   op_b;
  logic [prod_width-1:0] product;

  wb_mul_regs i_wb_mul_regs (
    .clk      (clk),
    .arst_n   (arst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .start    (start),
    .op_a     (op_a),
    .op_b     (op_b),
    .done     (done),
    .busy     (busy),
    .product  (product)
  );

  mul16_core i_mul16_core (
    .clk     (clk),
    .arst_n  (arst_n),
    .start   (start),
    .op_a    (op_a),
    .op_b    (op_b),
    .done    (done),
    .busy    (busy),
    .product (product)
  );

endmodule

// ==== dv/tb_wb_mul16.sv ====
// Wishbone multiplier testbench
`timescale 1ns/1ps

module tb_wb_mul16
  import mul_pkg::*;
  import wb_pkg::*;
();

  localparam int num_random      = 40;
  localparam int cycles_per_pair = 10;
  // Random pairs plus the fixed tests, four times over
  localparam int max_cycles      = 4 * (num_random + 10) * cycles_per_pair;

  logic                     clk;
  logic                     arst_n;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [wb_addr_width-1:0] wb_adr;
  logic [wb_data_width-1:0] wb_dat_w;
  logic [wb_data_width-1:0] wb_dat_r;
  logic                     wb_ack;

  int          cycles = 0;
  int          errors = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;
  int          err_mark = 0;
  int          ack_cycle = 0;
  string       cur_test = "none";
  logic [31:0] lfsr;

  wb_mul16_top i_wb_mul16_top (
    .clk      (clk),
    .arst_n   (arst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  initial begin
    wait (cycles >= max_cycles);
    $display("Timeout after %0d cycles, a bus transfer never finished", max_cycles);
    $display("Verification failed");
    $finish;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_word(output logic [31:0] w);
    w = '0;
    for (int n = 0; n < 32; n++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[30:0], lfsr[0]};
    end
  endtask

  // Operand a low, operand b high
  function automatic logic [31:0] expected_product(input logic [31:0] w);
    return 32'(w[15:0]) * 32'(w[31:16]);
  endfunction

  task automatic write_word(input logic [wb_addr_width-1:0] adr, input logic [31:0] data);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    do @(negedge clk); while (!wb_ack);
    ack_cycle = cycles;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic read_word(input logic [wb_addr_width-1:0] adr, output logic [31:0] data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    do @(negedge clk); while (!wb_ack);
    ack_cycle = cycles;
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    do begin
      read_word(addr_status, st);
    end while (st[status_busy_bit]);
  endtask

  task automatic expect_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAILED %s: %s expected %h actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err_mark = errors;
  endtask

  task automatic end_test();
    if (errors == err_mark) begin
      tests_ok++;
      $display("Test %s: ok", cur_test);
    end else begin
      tests_bad++;
      $display("Test %s: %0d check(s) failed", cur_test, errors - err_mark);
    end
  endtask

  ack_single: assert property (@(posedge clk) disable iff (!arst_n) wb_ack |=> !wb_ack)
    else begin
      $display("FAILED %s: wb_ack width expected 1 cycle actual 2 or more", cur_test);
      errors++;
    end

  initial begin
    logic [31:0] word;
    logic [31:0] rd;
    logic [31:0] corners [5];
    int          wr_ack;

    arst_n   = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    lfsr     = 32'hd228_d2b7;
    repeat (4) @(negedge clk);
    arst_n = 1'b1;

    begin_test("reset_state");
    expect_word("wb_ack", 32'h0, {31'b0, wb_ack});
    read_word(addr_status, rd);
    expect_word("status", 32'h0, rd);
    read_word(addr_product, rd);
    expect_word("product", 32'h0, rd);
    read_word(addr_operands, rd);
    expect_word("operands", 32'h0, rd);
    end_test();

    begin_test("operand_readback");
    write_word(addr_operands, 32'h3C5A_F00F);
    write_word(addr_operands, 32'hA5C3_1E69);
    read_word(addr_operands, rd);
    expect_word("last written word", 32'hA5C3_1E69, rd);
    end_test();

    // b in the upper half, a in the lower
    corners = '{32'h1234_0000, 32'hFFFF_FFFF, 32'h0001_FFFF, 32'h8000_8000, 32'hFF00_00FF};
    begin_test("corner_operands");
    for (int n = 0; n < 5; n++) begin
      write_word(addr_operands, corners[n]);
      read_word(addr_product, rd);
      expect_word($sformatf("corner %h", corners[n]), expected_product(corners[n]), rd);
    end
    end_test();

    begin_test("random_pairs");
    for (int n = 0; n < num_random; n++) begin
      draw_word(word);
      write_word(addr_operands, word);
      wait_idle();
      read_word(addr_product, rd);
      expect_word($sformatf("pair %0d %h", n, word), expected_product(word), rd);
    end
    end_test();

    begin_test("read_stall");
    write_word(addr_operands, 32'h5678_1234);
    wr_ack = ack_cycle;
    read_word(addr_product, rd);
    assert (ack_cycle - wr_ack >= pipe_depth) else begin
      $display("FAILED %s: ack distance expected >= %0d actual %0d",
               cur_test, pipe_depth, ack_cycle - wr_ack);
      errors++;
    end
    expect_word("new product", expected_product(32'h5678_1234), rd);
    end_test();

    begin_test("back_to_back");
    write_word(addr_operands, 32'h00C3_0A0B);
    write_word(addr_operands, 32'hBEEF_1357);
    @(negedge clk);
    expect_word("wb_ack after one cycle", 32'h0, {31'b0, wb_ack});
    wait_idle();
    read_word(addr_product, rd);
    expect_word("second pair product", expected_product(32'hBEEF_1357), rd);
    end_test();

    $display("Tests: %0d ok, %0d failed, %0d failed checks", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
common/mul_pkg.sv
common/wb_pkg.sv
mul16/array_mul8.sv
mul16/cla32.sv
mul16/mul16_core.sv
hw/wb_mul_regs.sv
hw/wb_mul16_top.sv
dv/tb_wb_mul16.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the multiplier testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_wb_mul16 -Mdir obj_dir -f flist.f; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_wb_mul16)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Verification passed" <<< "$sim_out"; then
  exit 0
fi

exit 1
